/* source/if_consts.svh */
/*
 * Instruction fetch constants
 * Bus widths, buffer sizing and trap vector layout
 */
`ifndef IF_CONSTS_SVH
`define IF_CONSTS_SVH
`default_nettype none

// Address and data width of the instruction bus
`define IF_XLEN         32
// Buffer sizing
`define IF_BUF_DEPTH    2
`define IF_MAX_OUTSTND  2
`define IF_CNT_W        2
// Trap vector layout
`define IF_EXC_OFFSET   7
`define IF_MTVEC_W      25
`define IF_CAUSE_W      5

`default_nettype wire
`endif

/* source/if_pkg.sv */
/*
 * Instruction fetch package
 * PC select encoding and the payloads of the fetch buffers
 */
`include "if_consts.svh"
`default_nettype none

package if_pkg;

  // Source of the next fetch address on a redirect
  typedef enum logic [2:0] {
    PC_BOOT     = 3'd0,
    PC_JUMP     = 3'd1,
    PC_BRANCH   = 3'd2,
    PC_MRET     = 3'd3,
    PC_DRET     = 3'd4,
    PC_TRAP_EXC = 3'd5,
    PC_TRAP_IRQ = 3'd6,
    PC_TRAP_DBD = 3'd7
  } pc_mux_e;

  // One granted request still waiting for its response
  typedef struct packed {
    logic [`IF_XLEN-1:0] addr;
    logic                stale;   // Overtaken by a redirect
  } pend_t;

  // One fetched word waiting for the IF/ID register
  typedef struct packed {
    logic [`IF_XLEN-1:0] pc;
    logic [`IF_XLEN-1:0] instr;
    logic                err;
  } fetch_word_t;

endpackage

`default_nettype wire

/* source/fifo_buf.sv */
/*
 * Small synchronous FIFO
 * Circular storage with read and write pointers and an occupancy count,
 * emptied in one cycle by flush
 */
`include "if_consts.svh"
`default_nettype none

module fifo_buf #(
  parameter type T     = logic [7:0],
  parameter int  DEPTH = 2
) (
  input  wire logic                 clk,
  input  wire logic                 rst_n,
  input  wire logic                 push_i,
  input  wire T                     data_i,
  input  wire logic                 pop_i,
  input  wire logic                 flush_i,
  output      T                     data_o,
  output      logic                 empty_o,
  output      logic [`IF_CNT_W-1:0] count_o
);

  localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;

  T                     mem [DEPTH];
  logic [PTR_W-1:0]     rptr_q;
  logic [PTR_W-1:0]     wptr_q;
  logic [`IF_CNT_W-1:0] count_q;
  logic                 push_ok;
  logic                 pop_ok;

  // Pop only real entries, push only into free space
  assign pop_ok  = pop_i && (count_q != '0);
  assign push_ok = push_i && ((count_q < `IF_CNT_W'(DEPTH)) || pop_ok);

  always_ff @(posedge clk, negedge rst_n) begin
    if (!rst_n) begin
      rptr_q  <= '0;
      wptr_q  <= '0;
      count_q <= '0;
    end else if (flush_i) begin
      rptr_q  <= '0;
      wptr_q  <= '0;
      count_q <= '0;
    end else begin
      // Pointers wrap at DEPTH
      if (push_ok) begin
        wptr_q <= (wptr_q == PTR_W'(DEPTH - 1)) ? '0 : wptr_q + 1'b1;
      end
      if (pop_ok) begin
        rptr_q <= (rptr_q == PTR_W'(DEPTH - 1)) ? '0 : rptr_q + 1'b1;
      end
      count_q <= count_q + `IF_CNT_W'(push_ok) - `IF_CNT_W'(pop_ok);
    end
  end

  // Storage
  always_ff @(posedge clk) begin
    if (push_ok && !flush_i) begin
      mem[wptr_q] <= data_i;
    end
  end

  assign data_o  = mem[rptr_q];
  assign empty_o = (count_q == '0);
  assign count_o = count_q;

endmodule

`default_nettype wire

/* source/fetch_requester.sv */
/*
 * Fetch requester
 * Selects the next PC on a redirect and issues word fetches on the
 * instruction bus, keeping a request stable until it is granted
 */
`include "if_consts.svh"
`default_nettype none

module fetch_requester (
  input  wire logic                   clk,
  input  wire logic                   rst_n,
  input  wire logic                   pc_set_i,
  input  wire if_pkg::pc_mux_e        pc_mux_i,
  input  wire logic [`IF_XLEN-1:0]    boot_addr_i,
  input  wire logic [`IF_XLEN-1:0]    jump_target_i,
  input  wire logic [`IF_XLEN-1:0]    branch_target_i,
  input  wire logic [`IF_XLEN-1:0]    mepc_i,
  input  wire logic [`IF_XLEN-1:0]    dpc_i,
  input  wire logic [`IF_XLEN-1:0]    dm_halt_addr_i,
  input  wire logic [`IF_MTVEC_W-1:0] mtvec_addr_i,
  input  wire logic [`IF_CAUSE_W-1:0] irq_cause_i,
  input  wire logic                   instr_gnt_i,
  input  wire logic                   fetch_credit_i,
  output      logic                   instr_req_o,
  output      logic [`IF_XLEN-1:0]    instr_addr_o,
  output      logic                   req_push_o,
  output      if_pkg::pend_t          req_entry_o,
  output      logic                   csr_mtvec_init_o
);

  logic [`IF_XLEN-1:0] target;
  logic [`IF_XLEN-1:0] next_addr;
  logic [`IF_XLEN-1:0] fetch_addr_q;
  logic [`IF_XLEN-1:0] req_addr_q;
  logic                req_q;
  logic                active_q;
  logic                stale_q;
  logic                can_issue;

  ////////////////////////////////////////////////////////////
  // Target selection
  ////////////////////////////////////////////////////////////

  always_comb begin
    target = {boot_addr_i[`IF_XLEN-1:2], 2'b00};
    case (pc_mux_i)
      if_pkg::PC_BOOT:     target = {boot_addr_i[`IF_XLEN-1:2], 2'b00};
      if_pkg::PC_JUMP:     target = jump_target_i;
      if_pkg::PC_BRANCH:   target = branch_target_i;
      if_pkg::PC_MRET:     target = {mepc_i[`IF_XLEN-1:2], 2'b00};
      if_pkg::PC_DRET:     target = dpc_i;
      // Exceptions share the vector base
      if_pkg::PC_TRAP_EXC: target = {mtvec_addr_i, `IF_EXC_OFFSET'(0)};
      // Interrupts are vectored by cause
      if_pkg::PC_TRAP_IRQ: target = {mtvec_addr_i, irq_cause_i, 2'b00};
      if_pkg::PC_TRAP_DBD: target = {dm_halt_addr_i[`IF_XLEN-1:2], 2'b00};
      default:             target = {boot_addr_i[`IF_XLEN-1:2], 2'b00};
    endcase
  end

  // Boot redirect tells the CSR file to set up mtvec
  assign csr_mtvec_init_o = pc_set_i && (pc_mux_i == if_pkg::PC_BOOT);

  ////////////////////////////////////////////////////////////
  // Request issue
  ////////////////////////////////////////////////////////////

  // Redirect target goes straight into the next request
  assign next_addr = pc_set_i ? {target[`IF_XLEN-1:2], 2'b00} : fetch_addr_q;

  // New request when the bus slot frees up and the buffer has room
  assign can_issue = (active_q || pc_set_i) && fetch_credit_i && (!req_q || instr_gnt_i);

  always_ff @(posedge clk, negedge rst_n) begin
    if (!rst_n) begin
      req_q        <= 1'b0;
      active_q     <= 1'b0;
      stale_q      <= 1'b0;
      req_addr_q   <= '0;
      fetch_addr_q <= '0;
    end else begin
      if (pc_set_i) begin
        active_q <= 1'b1;
      end
      // Held request stays up until granted
      req_q <= (req_q && !instr_gnt_i) || can_issue;
      if (can_issue) begin
        req_addr_q   <= next_addr;
        fetch_addr_q <= next_addr + `IF_XLEN'(4);
      end else if (pc_set_i) begin
        fetch_addr_q <= {target[`IF_XLEN-1:2], 2'b00};
      end
      // A waiting request overtaken by a redirect belongs to the old stream
      if (pc_set_i && req_q && !instr_gnt_i) begin
        stale_q <= 1'b1;
      end else if (instr_gnt_i) begin
        stale_q <= 1'b0;
      end
    end
  end

  assign instr_req_o  = req_q;
  assign instr_addr_o = req_addr_q;

  // Granted request enters the pending queue
  assign req_push_o  = req_q && instr_gnt_i;
  assign req_entry_o = '{addr: req_addr_q, stale: stale_q || pc_set_i};

endmodule

`default_nettype wire

/* source/fetch_buffer.sv */
/*
 * Fetch buffer
 * Pairs bus responses with their pending addresses, drops responses of
 * a redirected stream and queues the fetched words
 */
`include "if_consts.svh"
`default_nettype none

module fetch_buffer (
  input  wire logic                clk,
  input  wire logic                rst_n,
  input  wire logic                pc_set_i,
  input  wire logic                req_push_i,
  input  wire if_pkg::pend_t       req_entry_i,
  input  wire logic                instr_rvalid_i,
  input  wire logic [`IF_XLEN-1:0] instr_rdata_i,
  input  wire logic                instr_err_i,
  input  wire logic                buf_pop_i,
  output      logic                fetch_credit_o,
  output      logic                buf_valid_o,
  output      if_pkg::fetch_word_t buf_word_o
);

  if_pkg::pend_t        pend_head;
  if_pkg::fetch_word_t  word_in;
  logic                 pend_empty;
  logic                 word_empty;
  logic [`IF_CNT_W-1:0] pend_cnt;
  logic [`IF_CNT_W-1:0] word_cnt;
  logic [`IF_CNT_W-1:0] drop_cnt_q;
  logic [`IF_CNT_W:0]   occupancy;
  logic                 pend_pop;
  logic                 resp_keep;

  // Pending addresses, in grant order
  fifo_buf #(
    .T     (if_pkg::pend_t),
    .DEPTH (`IF_MAX_OUTSTND)
  ) pend_fifo (
    .clk     (clk),
    .rst_n   (rst_n),
    .push_i  (req_push_i),
    .data_i  (req_entry_i),
    .pop_i   (pend_pop),
    .flush_i (1'b0),
    .data_o  (pend_head),
    .empty_o (pend_empty),
    .count_o (pend_cnt)
  );

  // Each response retires the oldest pending address
  assign pend_pop = instr_rvalid_i && !pend_empty;

  // Old stream responses are dropped by count or by stale mark
  assign resp_keep = pend_pop && (drop_cnt_q == '0) && !pend_head.stale && !pc_set_i;

  always_ff @(posedge clk, negedge rst_n) begin
    if (!rst_n) begin
      drop_cnt_q <= '0;
    end else if (pc_set_i) begin
      // Everything in flight now is dropped, less the one retiring
      drop_cnt_q <= pend_cnt - `IF_CNT_W'(pend_pop);
    end else if (pend_pop && (drop_cnt_q != '0)) begin
      drop_cnt_q <= drop_cnt_q - 1'b1;
    end
  end

  assign word_in = '{pc: pend_head.addr, instr: instr_rdata_i, err: instr_err_i};

  // Fetched words, emptied on redirect
  fifo_buf #(
    .T     (if_pkg::fetch_word_t),
    .DEPTH (`IF_BUF_DEPTH)
  ) word_fifo (
    .clk     (clk),
    .rst_n   (rst_n),
    .push_i  (resp_keep),
    .data_i  (word_in),
    .pop_i   (buf_pop_i),
    .flush_i (pc_set_i),
    .data_o  (buf_word_o),
    .empty_o (word_empty),
    .count_o (word_cnt)
  );

  assign buf_valid_o = !word_empty;

  // Room for one more request beyond anything granted this cycle
  assign occupancy = {1'b0, pend_cnt} + {1'b0, word_cnt} + (`IF_CNT_W+1)'(req_push_i);
  assign fetch_credit_o = occupancy < (`IF_CNT_W+1)'(`IF_BUF_DEPTH);

endmodule

`default_nettype wire

/* source/if_id_register.sv */
/*
 * IF/ID pipeline register
 * Stage valid/ready toward decode and the registered instruction with
 * its compressed and abort flags
 */
`include "if_consts.svh"
`default_nettype none

module if_id_register (
  input  wire logic                clk,
  input  wire logic                rst_n,
  input  wire logic                buf_valid_i,
  input  wire if_pkg::fetch_word_t buf_word_i,
  input  wire logic                halt_if_i,
  input  wire logic                kill_if_i,
  input  wire logic                id_ready_i,
  output      logic                buf_pop_o,
  output      logic                if_valid_o,
  output      logic [`IF_XLEN-1:0] pc_if_o,
  output      logic                id_valid_o,
  output      logic [`IF_XLEN-1:0] id_pc_o,
  output      logic [`IF_XLEN-1:0] id_instr_o,
  output      logic                id_compressed_o,
  output      logic [15:0]         id_compressed_instr_o,
  output      logic                id_abort_o
);

  logic handshake;
  logic compressed;

  // Halt and kill hide the head word from decode
  assign if_valid_o = buf_valid_i && !halt_if_i && !kill_if_i;
  // Kill discards the head, otherwise it leaves on a handshake
  assign buf_pop_o  = kill_if_i || (buf_valid_i && id_ready_i && !halt_if_i);
  assign pc_if_o    = buf_word_i.pc;
  assign handshake  = if_valid_o && id_ready_i;

  // 32-bit words end in 2'b11
  assign compressed = (buf_word_i.instr[1:0] != 2'b11);

  always_ff @(posedge clk, negedge rst_n) begin
    if (!rst_n) begin
      id_valid_o            <= 1'b0;
      id_pc_o               <= '0;
      id_instr_o            <= '0;
      id_compressed_o       <= 1'b0;
      id_compressed_instr_o <= '0;
      id_abort_o            <= 1'b0;
    end else if (handshake) begin
      id_valid_o      <= 1'b1;
      id_pc_o         <= buf_word_i.pc;
      id_instr_o      <= buf_word_i.instr;
      id_compressed_o <= compressed;
      // Bus error aborts the instruction downstream
      id_abort_o      <= buf_word_i.err;
      if (compressed) begin
        id_compressed_instr_o <= buf_word_i.instr[15:0];
      end
    end else if (id_ready_i) begin
      // Decode took the last one, nothing new
      id_valid_o <= 1'b0;
    end
  end

endmodule

`default_nettype wire

/* source/if_stage.sv */
/*
 * Instruction fetch stage
 * Next-PC selection, instruction bus requests, response buffering
 * and the IF/ID pipeline register
 */
`include "if_consts.svh"
`default_nettype none

module if_stage (
  input  wire logic                   clk,
  input  wire logic                   rst_n,
  // Redirect control
  input  wire logic                   pc_set_i,
  input  wire if_pkg::pc_mux_e        pc_mux_i,
  input  wire logic [`IF_XLEN-1:0]    boot_addr_i,
  input  wire logic [`IF_XLEN-1:0]    jump_target_i,
  input  wire logic [`IF_XLEN-1:0]    branch_target_i,
  input  wire logic [`IF_XLEN-1:0]    mepc_i,
  input  wire logic [`IF_XLEN-1:0]    dpc_i,
  input  wire logic [`IF_XLEN-1:0]    dm_halt_addr_i,
  input  wire logic [`IF_MTVEC_W-1:0] mtvec_addr_i,
  input  wire logic [`IF_CAUSE_W-1:0] irq_cause_i,
  output      logic                   csr_mtvec_init_o,
  // Instruction bus
  output      logic                   instr_req_o,
  output      logic [`IF_XLEN-1:0]    instr_addr_o,
  input  wire logic                   instr_gnt_i,
  input  wire logic                   instr_rvalid_i,
  input  wire logic [`IF_XLEN-1:0]    instr_rdata_i,
  input  wire logic                   instr_err_i,
  // Stage control and decode side
  input  wire logic                   halt_if_i,
  input  wire logic                   kill_if_i,
  input  wire logic                   id_ready_i,
  output      logic                   if_valid_o,
  output      logic [`IF_XLEN-1:0]    pc_if_o,
  output      logic                   id_valid_o,
  output      logic [`IF_XLEN-1:0]    id_pc_o,
  output      logic [`IF_XLEN-1:0]    id_instr_o,
  output      logic                   id_compressed_o,
  output      logic [15:0]            id_compressed_instr_o,
  output      logic                   id_abort_o
);

  logic                req_push;
  if_pkg::pend_t       req_entry;
  logic                fetch_credit;
  logic                buf_valid;
  if_pkg::fetch_word_t buf_word;
  logic                buf_pop;

  fetch_requester u_requester (
    .clk              (clk),
    .rst_n            (rst_n),
    .pc_set_i         (pc_set_i),
    .pc_mux_i         (pc_mux_i),
    .boot_addr_i      (boot_addr_i),
    .jump_target_i    (jump_target_i),
    .branch_target_i  (branch_target_i),
    .mepc_i           (mepc_i),
    .dpc_i            (dpc_i),
    .dm_halt_addr_i   (dm_halt_addr_i),
    .mtvec_addr_i     (mtvec_addr_i),
    .irq_cause_i      (irq_cause_i),
    .instr_gnt_i      (instr_gnt_i),
    .fetch_credit_i   (fetch_credit),
    .instr_req_o      (instr_req_o),
    .instr_addr_o     (instr_addr_o),
    .req_push_o       (req_push),
    .req_entry_o      (req_entry),
    .csr_mtvec_init_o (csr_mtvec_init_o)
  );

  fetch_buffer u_buffer (
    .clk            (clk),
    .rst_n          (rst_n),
    .pc_set_i       (pc_set_i),
    .req_push_i     (req_push),
    .req_entry_i    (req_entry),
    .instr_rvalid_i (instr_rvalid_i),
    .instr_rdata_i  (instr_rdata_i),
    .instr_err_i    (instr_err_i),
    .buf_pop_i      (buf_pop),
    .fetch_credit_o (fetch_credit),
    .buf_valid_o    (buf_valid),
    .buf_word_o     (buf_word)
  );

  if_id_register u_if_id (
    .clk                   (clk),
    .rst_n                 (rst_n),
    .buf_valid_i           (buf_valid),
    .buf_word_i            (buf_word),
    .halt_if_i             (halt_if_i),
    .kill_if_i             (kill_if_i),
    .id_ready_i            (id_ready_i),
    .buf_pop_o             (buf_pop),
    .if_valid_o            (if_valid_o),
    .pc_if_o               (pc_if_o),
    .id_valid_o            (id_valid_o),
    .id_pc_o               (id_pc_o),
    .id_instr_o            (id_instr_o),
    .id_compressed_o       (id_compressed_o),
    .id_compressed_instr_o (id_compressed_instr_o),
    .id_abort_o            (id_abort_o)
  );

endmodule

`default_nettype wire

/* test/if_stage_checker.sv */
/*
 * Fetch stage protocol checker
 * Bus request stability, address alignment and decode handshake rules
 */
`include "if_consts.svh"
`default_nettype none

module if_stage_checker (
  input wire logic                clk,
  input wire logic                rst_n,
  input wire logic                instr_req_i,
  input wire logic [`IF_XLEN-1:0] instr_addr_i,
  input wire logic                instr_gnt_i,
  input wire logic                halt_if_i,
  input wire logic                kill_if_i,
  input wire logic                if_valid_i,
  input wire logic                id_ready_i,
  input wire logic                id_valid_i,
  input wire logic [`IF_XLEN-1:0] id_pc_i,
  input wire logic [`IF_XLEN-1:0] id_instr_i,
  input wire logic                id_abort_i
);

  timeunit 1ns;
  timeprecision 100ps;

  int unsigned hold_errs  = 0;
  int unsigned align_errs = 0;
  int unsigned valid_errs = 0;
  int unsigned stall_errs = 0;

  // Request and address wait for the grant
  req_hold: assert property (@(posedge clk) disable iff (!rst_n)
    instr_req_i && !instr_gnt_i |=> instr_req_i && $stable(instr_addr_i))
    else begin
      $error("instr_req_o dropped or instr_addr_o moved before grant");
      hold_errs++;
    end

  // Word fetches only
  addr_align: assert property (@(posedge clk) disable iff (!rst_n)
    instr_req_i |-> (instr_addr_i[1:0] == 2'b00))
    else begin
      $error("instr_addr_o not word aligned");
      align_errs++;
    end

  // No word reaches decode while halt or kill hides the head
  valid_masked: assert property (@(posedge clk) disable iff (!rst_n)
    (halt_if_i || kill_if_i) && !id_valid_i |=> !id_valid_i)
    else begin
      $error("word reached decode during halt or kill");
      valid_errs++;
    end

  // Decode stall freezes the IF/ID register
  id_hold: assert property (@(posedge clk) disable iff (!rst_n)
    !id_ready_i |=> $stable(id_valid_i) && $stable(id_pc_i) && $stable(id_instr_i)
                    && $stable(id_abort_i))
    else begin
      $error("IF/ID outputs changed while id_ready_i low");
      stall_errs++;
    end

endmodule

bind if_stage if_stage_checker u_checker (
  .clk          (clk),
  .rst_n        (rst_n),
  .instr_req_i  (instr_req_o),
  .instr_addr_i (instr_addr_o),
  .instr_gnt_i  (instr_gnt_i),
  .halt_if_i    (halt_if_i),
  .kill_if_i    (kill_if_i),
  .if_valid_i   (if_valid_o),
  .id_ready_i   (id_ready_i),
  .id_valid_i   (id_valid_o),
  .id_pc_i      (id_pc_o),
  .id_instr_i   (id_instr_o),
  .id_abort_i   (id_abort_o)
);

`default_nettype wire

/* test/if_stage_tb.sv */
/*
 * Instruction fetch stage testbench
 * Drives redirects and stage control, models a randomized instruction
 * bus and compares the words handed to decode with the fetch rules
 */
`include "if_consts.svh"
`default_nettype none

module if_stage_tb;

  timeunit 1ns;
  timeprecision 100ps;

  // Run limit from six tests of up to 300 cycles each, doubled, plus reset
  localparam int          TESTS        = 6;
  localparam int          CYC_PER_TEST = 300;
  localparam int          MAX_CYCLES   = TESTS * CYC_PER_TEST * 2 + 400;
  localparam int          WAIT_LIMIT   = 200;
  localparam logic [31:0] BOOT_ADDR    = 32'h0000_1000;
  // Bus error window
  localparam logic [31:0] ERR_LO       = 32'h0000_2040;
  localparam logic [31:0] ERR_HI       = 32'h0000_2050;

  logic                   clk;
  logic                   rst_n;
  logic                   pc_set_i;
  if_pkg::pc_mux_e        pc_mux_i;
  logic [`IF_XLEN-1:0]    boot_addr_i;
  logic [`IF_XLEN-1:0]    jump_target_i;
  logic [`IF_XLEN-1:0]    branch_target_i;
  logic [`IF_XLEN-1:0]    mepc_i;
  logic [`IF_XLEN-1:0]    dpc_i;
  logic [`IF_XLEN-1:0]    dm_halt_addr_i;
  logic [`IF_MTVEC_W-1:0] mtvec_addr_i;
  logic [`IF_CAUSE_W-1:0] irq_cause_i;
  logic                   csr_mtvec_init_o;
  logic                   instr_req_o;
  logic [`IF_XLEN-1:0]    instr_addr_o;
  logic                   instr_gnt_i;
  logic                   instr_rvalid_i;
  logic [`IF_XLEN-1:0]    instr_rdata_i;
  logic                   instr_err_i;
  logic                   halt_if_i;
  logic                   kill_if_i;
  logic                   id_ready_i;
  logic                   if_valid_o;
  logic [`IF_XLEN-1:0]    pc_if_o;
  logic                   id_valid_o;
  logic [`IF_XLEN-1:0]    id_pc_o;
  logic [`IF_XLEN-1:0]    id_instr_o;
  logic                   id_compressed_o;
  logic [15:0]            id_compressed_instr_o;
  logic                   id_abort_o;

  logic [31:0] rng_state = 32'hd9d8;
  int          cyc;
  int          errors;
  int          checks;
  int          outstanding;
  int          mtvec_pulses;
  int          boot_redirects;
  // Bus model response queue
  logic [31:0] resp_addr_q[$];
  int          resp_due_q[$];
  // Words taken by decode
  logic [31:0] seen_pc[$];
  logic [31:0] seen_instr[$];
  logic        seen_c[$];
  logic [15:0] seen_ci[$];
  logic        seen_abort[$];

  if_stage dut (.*);

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  // Cycle counter and run limit
  initial begin
    cyc = 0;
    forever begin
      @(posedge clk);
      cyc = cyc + 1;
      if (cyc >= MAX_CYCLES) begin
        $display("Timeout: run exceeded %0d cycles", MAX_CYCLES);
        $display("Test FAILED");
        $finish;
      end
    end
  end

  ////////////////////////////////////////////////////////////
  // Memory and bus model
  ////////////////////////////////////////////////////////////

  function automatic logic [31:0] next_rand();
    rng_state = rng_state ^ (rng_state << 13);
    rng_state = rng_state ^ (rng_state >> 17);
    rng_state = rng_state ^ (rng_state << 5);
    return rng_state;
  endfunction

  // Address bit 3 turns the word into a compressed one
  function automatic logic [31:0] mem_word(input logic [31:0] addr);
    logic [31:0] w;
    w = addr ^ 32'h5a5a_0003;
    if (addr[3]) begin
      w[1:0] = 2'b01;
    end
    return w;
  endfunction

  function automatic logic in_err_window(input logic [31:0] addr);
    return (addr >= ERR_LO) && (addr < ERR_HI);
  endfunction

  // Decides at the falling edge, drives just after the rising edge
  initial begin
    logic        rvalid_nxt;
    logic        err_nxt;
    logic [31:0] rdata_nxt;
    int          gnt_wait;
    int          last_due;
    int          due;
    gnt_wait       = 0;
    last_due       = 0;
    outstanding    = 0;
    instr_gnt_i    = 1'b0;
    instr_rvalid_i = 1'b0;
    instr_rdata_i  = '0;
    instr_err_i    = 1'b0;
    forever begin
      @(negedge clk);
      rvalid_nxt = 1'b0;
      err_nxt    = 1'b0;
      rdata_nxt  = '0;
      if (rst_n && instr_req_o && instr_gnt_i) begin
        // Grant lands on the coming edge, answer 1 to 3 cycles later, in order
        due = cyc + 1 + 1 + int'(next_rand() % 3);
        if (due <= last_due) begin
          due = last_due + 1;
        end
        last_due = due;
        resp_addr_q.push_back(instr_addr_o);
        resp_due_q.push_back(due);
        gnt_wait = int'(next_rand() % 3);
      end else if (instr_req_o && (gnt_wait > 0)) begin
        gnt_wait--;
      end
      outstanding = resp_addr_q.size();
      if ((resp_due_q.size() > 0) && (resp_due_q[0] == cyc + 2)) begin
        rvalid_nxt = 1'b1;
        rdata_nxt  = mem_word(resp_addr_q[0]);
        err_nxt    = in_err_window(resp_addr_q[0]);
        void'(resp_addr_q.pop_front());
        void'(resp_due_q.pop_front());
      end
      @(posedge clk);
      #2;
      instr_gnt_i    = (gnt_wait == 0);
      instr_rvalid_i = rvalid_nxt;
      instr_rdata_i  = rdata_nxt;
      instr_err_i    = err_nxt;
    end
  end

  // Decode side monitor, a word counts once when decode takes it
  always @(negedge clk) begin
    if (rst_n && id_valid_o && id_ready_i) begin
      seen_pc.push_back(id_pc_o);
      seen_instr.push_back(id_instr_o);
      seen_c.push_back(id_compressed_o);
      seen_ci.push_back(id_compressed_instr_o);
      seen_abort.push_back(id_abort_o);
    end
    if (rst_n && csr_mtvec_init_o) begin
      mtvec_pulses++;
    end
  end

  ////////////////////////////////////////////////////////////
  // Helpers
  ////////////////////////////////////////////////////////////

  task automatic check(input logic [31:0] actual, input logic [31:0] expected,
                       input string msg);
    checks++;
    if (actual !== expected) begin
      $display("Fail %0t: %s, got %h, expected %h", $time, msg, actual, expected);
      errors++;
    end
  endtask

  task automatic clear_seen();
    seen_pc.delete();
    seen_instr.delete();
    seen_c.delete();
    seen_ci.delete();
    seen_abort.delete();
  endtask

  task automatic wait_words(input int n);
    int waited;
    waited = 0;
    while ((seen_pc.size() < n) && (waited < WAIT_LIMIT)) begin
      @(posedge clk);
      #2;
      waited++;
    end
    if (seen_pc.size() < n) begin
      $display("Error at %0t: only %0d of %0d words reached decode", $time,
               seen_pc.size(), n);
      errors++;
    end
  endtask

  // Every field of one decode word against the memory model
  task automatic check_word(input int idx, input logic [31:0] exp_pc);
    logic [31:0] exp_instr;
    logic        exp_c;
    exp_instr = mem_word(exp_pc);
    exp_c     = (exp_instr[1:0] != 2'b11);
    if (idx >= seen_pc.size()) begin
      $display("Error at %0t: word for pc %h never reached decode", $time, exp_pc);
      errors++;
    end else begin
      check(seen_pc[idx], exp_pc, "id_pc_o");
      check(seen_instr[idx], exp_instr, "id_instr_o");
      check(32'(seen_c[idx]), 32'(exp_c), "id_compressed_o");
      if (exp_c) begin
        check(32'(seen_ci[idx]), 32'(exp_instr[15:0]), "id_compressed_instr_o");
      end
      check(32'(seen_abort[idx]), 32'(in_err_window(exp_pc)), "id_abort_o");
    end
  endtask

  task automatic check_stream(input int n, input logic [31:0] start);
    for (int i = 0; i < n; i++) begin
      check_word(i, start + 32'(4 * i));
    end
  endtask

  // Pulse pc_set, then drop the one word that may still have left the old stream
  task automatic redirect(input if_pkg::pc_mux_e mux);
    pc_set_i = 1'b1;
    pc_mux_i = mux;
    if (mux == if_pkg::PC_BOOT) begin
      boot_redirects++;
    end
    @(posedge clk);
    #2;
    pc_set_i = 1'b0;
    @(posedge clk);
    #2;
    clear_seen();
  endtask

  ////////////////////////////////////////////////////////////
  // Tests
  ////////////////////////////////////////////////////////////

  task automatic test_boot();
    boot_addr_i = BOOT_ADDR | 32'h2;
    redirect(if_pkg::PC_BOOT);
    wait_words(8);
    check(32'(mtvec_pulses), 32'(boot_redirects), "csr_mtvec_init_o pulses after boot");
    check_stream(8, BOOT_ADDR);
  endtask

  task automatic test_targets();
    logic [31:0]     exp_pc;
    if_pkg::pc_mux_e mux;
    jump_target_i   = 32'h0000_3104;
    branch_target_i = 32'h0000_3208;
    mepc_i          = 32'h0000_330e;
    dpc_i           = 32'h0000_3410;
    dm_halt_addr_i  = 32'h0000_3503;
    mtvec_addr_i    = 25'h00_006b;
    irq_cause_i     = 5'd9;
    for (int m = 0; m < 8; m++) begin
      mux = if_pkg::pc_mux_e'(m);
      case (mux)
        if_pkg::PC_BOOT:     exp_pc = boot_addr_i & ~32'h3;
        if_pkg::PC_JUMP:     exp_pc = jump_target_i & ~32'h3;
        if_pkg::PC_BRANCH:   exp_pc = branch_target_i & ~32'h3;
        if_pkg::PC_MRET:     exp_pc = mepc_i & ~32'h3;
        if_pkg::PC_DRET:     exp_pc = dpc_i & ~32'h3;
        if_pkg::PC_TRAP_EXC: exp_pc = {mtvec_addr_i, {`IF_EXC_OFFSET{1'b0}}};
        if_pkg::PC_TRAP_IRQ: exp_pc = {mtvec_addr_i, irq_cause_i, 2'b00};
        default:             exp_pc = dm_halt_addr_i & ~32'h3;
      endcase
      redirect(mux);
      wait_words(2);
      check_word(0, exp_pc);
      check_word(1, exp_pc + 32'h4);
    end
    check(32'(mtvec_pulses), 32'(boot_redirects), "csr_mtvec_init_o pulse count");
  endtask

  task automatic test_midflight();
    int waited;
    jump_target_i = 32'h0000_1800;
    redirect(if_pkg::PC_JUMP);
    wait_words(2);
    waited = 0;
    while ((outstanding < 2) && (waited < WAIT_LIMIT)) begin
      @(posedge clk);
      #2;
      waited++;
    end
    if (outstanding < 2) begin
      $display("Error at %0t: two fetches were never outstanding together", $time);
      errors++;
    end
    branch_target_i = 32'h0000_1c00;
    redirect(if_pkg::PC_BRANCH);
    wait_words(6);
    check_stream(6, 32'h0000_1c00);
  endtask

  task automatic test_backpressure();
    logic [31:0] r;
    int          waited;
    jump_target_i = 32'h0000_0800;
    redirect(if_pkg::PC_JUMP);
    waited = 0;
    while ((seen_pc.size() < 16) && (waited < 2 * WAIT_LIMIT)) begin
      r          = next_rand();
      id_ready_i = r[4];
      @(posedge clk);
      #2;
      waited++;
    end
    id_ready_i = 1'b1;
    wait_words(16);
    check_stream(16, 32'h0000_0800);
  endtask

  task automatic test_flags();
    int n_c;
    int n_abort;
    n_c     = 0;
    n_abort = 0;
    jump_target_i = ERR_LO - 32'h10;
    redirect(if_pkg::PC_JUMP);
    wait_words(12);
    check_stream(12, ERR_LO - 32'h10);
    for (int i = 0; i < seen_pc.size(); i++) begin
      n_c     += int'(seen_c[i]);
      n_abort += int'(seen_abort[i]);
    end
    check(32'(n_c > 0), 32'd1, "compressed words present");
    check(32'(n_abort > 0), 32'd1, "aborted words present");
  endtask

  task automatic test_halt_kill();
    int held;
    jump_target_i = 32'h0000_2800;
    redirect(if_pkg::PC_JUMP);
    wait_words(4);
    halt_if_i = 1'b1;
    @(posedge clk);
    #2;
    held = seen_pc.size();
    repeat (20) begin
      @(posedge clk);
      #2;
    end
    check(32'(seen_pc.size()), 32'(held), "words reaching decode during halt");
    // Head of the held buffer is the next word of the stream
    check(pc_if_o, 32'h0000_2800 + 32'(4 * held), "pc_if_o during halt");
    // Buffer is full here, kill drops exactly its head
    kill_if_i = 1'b1;
    @(posedge clk);
    #2;
    kill_if_i = 1'b0;
    repeat (10) begin
      @(posedge clk);
      #2;
    end
    halt_if_i = 1'b0;
    wait_words(held + 6);
    check_stream(held, 32'h0000_2800);
    for (int i = 0; i < 6; i++) begin
      check_word(held + i, 32'h0000_2800 + 32'(4 * (held + 1 + i)));
    end
  endtask

  ////////////////////////////////////////////////////////////
  // Main sequence
  ////////////////////////////////////////////////////////////

  initial begin
    int assert_fails;
    errors          = 0;
    checks          = 0;
    mtvec_pulses    = 0;
    boot_redirects  = 0;
    rst_n           = 1'b0;
    pc_set_i        = 1'b0;
    pc_mux_i        = if_pkg::PC_BOOT;
    boot_addr_i     = '0;
    jump_target_i   = '0;
    branch_target_i = '0;
    mepc_i          = '0;
    dpc_i           = '0;
    dm_halt_addr_i  = '0;
    mtvec_addr_i    = '0;
    irq_cause_i     = '0;
    halt_if_i       = 1'b0;
    kill_if_i       = 1'b0;
    id_ready_i      = 1'b1;
    repeat (3) @(posedge clk);
    #2;
    rst_n = 1'b1;
    // Nothing moves before the first redirect
    repeat (5) begin
      @(posedge clk);
      #2;
    end
    check(32'(instr_req_o), 32'd0, "instr_req_o idle before first redirect");
    check(32'(if_valid_o), 32'd0, "if_valid_o idle before first redirect");
    check(32'(id_valid_o), 32'd0, "id_valid_o idle before first redirect");
    check(32'(csr_mtvec_init_o), 32'd0, "csr_mtvec_init_o idle after reset");
    test_boot();
    test_targets();
    test_midflight();
    test_backpressure();
    test_flags();
    test_halt_kill();
    assert_fails = int'(dut.u_checker.hold_errs + dut.u_checker.align_errs +
                        dut.u_checker.valid_errs + dut.u_checker.stall_errs);
    $display("Checks: %0d, errors: %0d, assertion failures: %0d", checks, errors,
             assert_fails);
    if ((errors == 0) && (assert_fails == 0)) begin
      $display("Test OK");
    end else begin
      $display("Test FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* project.f */
+incdir+source
source/if_pkg.sv
source/fifo_buf.sv
source/fetch_requester.sv
source/fetch_buffer.sv
source/if_id_register.sv
source/if_stage.sv
test/if_stage_checker.sv
test/if_stage_tb.sv

/* Makefile */
# Verilator flow for the instruction fetch stage
TOP      ?= if_stage_tb
LOG      ?= sim.log
FLAGS    ?= --timing --assert
FILELIST ?= project.f
OBJ_DIR  ?= obj_dir
SIM_ARGS ?= +verilator+error+limit+1000

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only -Wall $(FLAGS) -f $(FILELIST) --top-module $(TOP)

sim:
	verilator --binary $(FLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) $(SIM_ARGS) 2>&1 | tee $(LOG)
	@if grep -q "Test FAILED" $(LOG) || ! grep -q "Test OK" $(LOG); then \
	  echo "Simulation failed, see $(LOG)"; \
	  exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
